// File: Makefile
SRCS := $(wildcard hw/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

obj_dir/Vtb_cpu: project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cpu -f project.f -o Vtb_cpu

clean:
	rm -rf obj_dir sim.log

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]          rdata1_i,
    input  logic [31:0]          rdata2_i,
    input  logic [31:0]          imm_i,
    input  logic                 alu_src_i,
    input  cpu_isa_pkg::alu_op_e alu_op_i,
    input  logic                 bne_i,
    output logic [31:0]          result_o,
    output logic                 zero_o
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic        equal;

    assign op_a  = rdata1_i;
    // immediate for op-imm, lui, loads, stores and jalr
    assign op_b  = alu_src_i ? imm_i : rdata2_i;
    // shift amount, low 5 bits only
    assign shamt = op_b[4:0];

    // ------------------------------------------------------------------------
    // arithmetic and logic
    // ------------------------------------------------------------------------
    always_comb begin
        case (alu_op_i)
            cpu_isa_pkg::ALU_ADD:    result_o = op_a + op_b;
            cpu_isa_pkg::ALU_SUB:    result_o = op_a - op_b;
            cpu_isa_pkg::ALU_AND:    result_o = op_a & op_b;
            cpu_isa_pkg::ALU_OR:     result_o = op_a | op_b;
            cpu_isa_pkg::ALU_XOR:    result_o = op_a ^ op_b;
            // signed compare
            cpu_isa_pkg::ALU_SLT:    result_o = {31'd0, $signed(op_a) < $signed(op_b)};
            cpu_isa_pkg::ALU_SLL:    result_o = op_a << shamt;
            cpu_isa_pkg::ALU_SRL:    result_o = op_a >> shamt;
            cpu_isa_pkg::ALU_SRA:    result_o = $unsigned($signed(op_a) >>> shamt);
            cpu_isa_pkg::ALU_PASS_B: result_o = op_b;
            default:                 result_o = op_a + op_b;
        endcase
    end

    // branch condition
    // always the register pair, never the immediate
    assign equal  = (rdata1_i == rdata2_i);
    assign zero_o = bne_i ? !equal : equal;

endmodule

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int IMEM_WORDS = cpu_mem_pkg::IMEM_WORDS_DEF,
    parameter int DMEM_WORDS = cpu_mem_pkg::DMEM_WORDS_DEF
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          run_i,
    input  logic                          prog_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr_i,
    input  logic [31:0]                   prog_data_i,
    input  logic [15:0]                   switch_i,
    output logic                          io_wr_o,
    output logic [31:0]                   io_wdata_o,
    output logic [15:0]                   led_o
);

    // ------------------------------------------------------------------------
    // internal wires
    // ------------------------------------------------------------------------
    logic [31:0]          instr;
    logic [31:0]          pc4;
    logic [31:0]          rdata1;
    logic [31:0]          rdata2;
    logic [31:0]          imm;
    logic [31:0]          alu_result;
    logic [31:0]          wb_data;
    cpu_isa_pkg::alu_op_e alu_op;
    logic                 alu_src;
    logic                 zero;
    logic                 branch;
    logic                 bne;
    logic                 jump;
    logic                 jalr;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_to_reg;

    // fetch and next pc
    ifetch #(
        .IMEM_WORDS(IMEM_WORDS)
    ) ifetch0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .run_i       (run_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .imm_i       (imm),
        .branch_i    (branch),
        .jump_i      (jump),
        .jalr_i      (jalr),
        .zero_i      (zero),
        .alu_result_i(alu_result),
        .instr_o     (instr),
        .pc4_o       (pc4)
    );

    // decode and register file
    decoder decoder0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .run_i       (run_i),
        .instr_i     (instr),
        .wb_data_i   (wb_data),
        .rdata1_o    (rdata1),
        .rdata2_o    (rdata2),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .alu_src_o   (alu_src),
        .branch_o    (branch),
        .bne_o       (bne),
        .jump_o      (jump),
        .jalr_o      (jalr),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .mem_to_reg_o(mem_to_reg)
    );

    alu alu0 (
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .imm_i    (imm),
        .alu_src_i(alu_src),
        .alu_op_i (alu_op),
        .bne_i    (bne),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    // alu result doubles as the memory address
    mem_or_io #(
        .DMEM_WORDS(DMEM_WORDS)
    ) mem_or_io0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .run_i       (run_i),
        .mem_read_i  (mem_read),
        .mem_write_i (mem_write),
        .mem_to_reg_i(mem_to_reg),
        .jump_i      (jump),
        .addr_i      (alu_result),
        .wdata_i     (rdata2),
        .alu_result_i(alu_result),
        .pc4_i       (pc4),
        .switch_i    (switch_i),
        .wb_data_o   (wb_data),
        .io_wr_o     (io_wr_o),
        .io_wdata_o  (io_wdata_o),
        .led_o       (led_o)
    );

endmodule

// File: hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // ------------------------------------------------------------------------
    // opcode groups of the supported rv32i subset
    // ------------------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // alu selector, pass_b forwards operand b untouched for lui
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // funct3 codes, arithmetic group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // funct3 codes, branch group
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 that flips add->sub and srl->sra
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    // ------------------------------------------------------------------------
    // instruction formats, all 32 bits wide
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views of it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

// File: hw/cpu_mem_pkg.sv
package cpu_mem_pkg;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    // everything at or above io_base is io, the rest is data memory
    localparam logic [31:0] IO_BASE  = 32'hFFFF_FC00;

    // store target for the led register
    localparam logic [31:0] LED_ADDR = 32'hFFFF_FC60;
    // load source for the switches
    localparam logic [31:0] SW_ADDR  = 32'hFFFF_FC70;

    // default depths in 32-bit words
    localparam int IMEM_WORDS_DEF = 256;
    localparam int DMEM_WORDS_DEF = 256;

endpackage

// File: hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 run_i,
    input  logic [31:0]          instr_i,
    input  logic [31:0]          wb_data_i,
    output logic [31:0]          rdata1_o,
    output logic [31:0]          rdata2_o,
    output logic [31:0]          imm_o,
    output cpu_isa_pkg::alu_op_e alu_op_o,
    output logic                 alu_src_o,
    output logic                 branch_o,
    output logic                 bne_o,
    output logic                 jump_o,
    output logic                 jalr_o,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output logic                 mem_to_reg_o
);

    cpu_isa_pkg::instr_u  ins;
    cpu_isa_pkg::opcode_e opc;
    logic [2:0]           f3;
    logic                 alt;
    logic                 reg_write;
    logic                 rf_we;
    logic [31:0]          rf [32];

    assign ins = instr_i;
    assign opc = cpu_isa_pkg::opcode_e'(ins.r.opcode);
    assign f3  = ins.r.funct3;
    // funct7 only matters for register-register ops
    assign alt = (opc == cpu_isa_pkg::OPC_OP) && (ins.r.funct7 == cpu_isa_pkg::F7_ALT);

    // funct3 to alu selector
    function automatic cpu_isa_pkg::alu_op_e f3_to_op(input logic [2:0] code, input logic sub);
        case (code)
            cpu_isa_pkg::F3_ADD_SUB: return sub ? cpu_isa_pkg::ALU_SUB : cpu_isa_pkg::ALU_ADD;
            cpu_isa_pkg::F3_SLL:     return cpu_isa_pkg::ALU_SLL;
            cpu_isa_pkg::F3_SLT:     return cpu_isa_pkg::ALU_SLT;
            cpu_isa_pkg::F3_XOR:     return cpu_isa_pkg::ALU_XOR;
            cpu_isa_pkg::F3_SRL_SRA: return sub ? cpu_isa_pkg::ALU_SRA : cpu_isa_pkg::ALU_SRL;
            cpu_isa_pkg::F3_OR:      return cpu_isa_pkg::ALU_OR;
            cpu_isa_pkg::F3_AND:     return cpu_isa_pkg::ALU_AND;
            default:                 return cpu_isa_pkg::ALU_ADD;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // control and immediate
    // ------------------------------------------------------------------------
    always_comb begin
        alu_op_o     = cpu_isa_pkg::ALU_ADD;
        alu_src_o    = 1'b0;
        branch_o     = 1'b0;
        bne_o        = 1'b0;
        jump_o       = 1'b0;
        jalr_o       = 1'b0;
        mem_read_o   = 1'b0;
        mem_write_o  = 1'b0;
        mem_to_reg_o = 1'b0;
        reg_write    = 1'b0;
        imm_o        = '0;
        case (opc)
            cpu_isa_pkg::OPC_OP: begin
                reg_write = 1'b1;
                alu_op_o  = f3_to_op(f3, alt);
            end
            cpu_isa_pkg::OPC_OP_IMM: begin
                reg_write = 1'b1;
                alu_src_o = 1'b1;
                alu_op_o  = f3_to_op(f3, 1'b0);
                imm_o     = {{20{ins.i.imm[11]}}, ins.i.imm};
            end
            cpu_isa_pkg::OPC_LUI: begin
                reg_write = 1'b1;
                alu_src_o = 1'b1;
                alu_op_o  = cpu_isa_pkg::ALU_PASS_B;
                imm_o     = {ins.u.imm31_12, 12'b0};
            end
            cpu_isa_pkg::OPC_LOAD: begin
                // word loads only
                // address is rs1 + imm
                reg_write    = 1'b1;
                alu_src_o    = 1'b1;
                mem_read_o   = 1'b1;
                mem_to_reg_o = 1'b1;
                imm_o        = {{20{ins.i.imm[11]}}, ins.i.imm};
            end
            cpu_isa_pkg::OPC_STORE: begin
                alu_src_o   = 1'b1;
                mem_write_o = 1'b1;
                imm_o       = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
            end
            cpu_isa_pkg::OPC_BRANCH: begin
                // only beq and bne are decoded
                branch_o = (f3 == cpu_isa_pkg::F3_BEQ) || (f3 == cpu_isa_pkg::F3_BNE);
                bne_o    = (f3 == cpu_isa_pkg::F3_BNE);
                alu_op_o = cpu_isa_pkg::ALU_SUB;
                imm_o    = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11,
                            ins.b.imm10_5, ins.b.imm4_1, 1'b0};
            end
            cpu_isa_pkg::OPC_JAL: begin
                reg_write = 1'b1;
                jump_o    = 1'b1;
                imm_o     = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12,
                             ins.j.imm11, ins.j.imm10_1, 1'b0};
            end
            cpu_isa_pkg::OPC_JALR: begin
                // target rs1 + imm comes out of the alu
                reg_write = 1'b1;
                jump_o    = 1'b1;
                jalr_o    = 1'b1;
                alu_src_o = 1'b1;
                imm_o     = {{20{ins.i.imm[11]}}, ins.i.imm};
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------------
    // no write to x0 and nothing while stopped
    assign rf_we = run_i && reg_write && (ins.r.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 32; k++) begin
                rf[k] <= '0;
            end
        end else if (rf_we) begin
            rf[ins.r.rd] <= wb_data_i;
        end
    end

    // x0 reads as zero
    assign rdata1_o = (ins.r.rs1 == 5'd0) ? 32'd0 : rf[ins.r.rs1];
    assign rdata2_o = (ins.r.rs2 == 5'd0) ? 32'd0 : rf[ins.r.rs2];

endmodule

// File: hw/ifetch.sv
`timescale 1ns/1ps

module ifetch #(
    parameter int IMEM_WORDS = cpu_mem_pkg::IMEM_WORDS_DEF
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          run_i,
    input  logic                          prog_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr_i,
    input  logic [31:0]                   prog_data_i,
    input  logic [31:0]                   imm_i,
    input  logic                          branch_i,
    input  logic                          jump_i,
    input  logic                          jalr_i,
    input  logic                          zero_i,
    input  logic [31:0]                   alu_result_i,
    output logic [31:0]                   instr_o,
    output logic [31:0]                   pc4_o
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] pc_next;

    // load port, word indexed, accepted on any edge
    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            imem[prog_addr_i] <= prog_data_i;
        end
    end

    // async read, word index from pc
    assign instr_o = imem[pc[AW+1:2]];
    assign pc4_o   = pc + 32'd4;

    // next pc
    // jalr wins over the plain jump target
    always_comb begin
        if (jalr_i) begin
            pc_next = {alu_result_i[31:1], 1'b0};
        end else if (jump_i || (branch_i && zero_i)) begin
            pc_next = pc + imm_i;
        end else begin
            pc_next = pc4_o;
        end
    end

    // held at zero while the core is stopped
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= '0;
        end else if (!run_i) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // pc stays on a word boundary across every redirect
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        run_i |=> (pc[1:0] == 2'b00)
    );

endmodule

// File: hw/mem_or_io.sv
`timescale 1ns/1ps

module mem_or_io #(
    parameter int DMEM_WORDS = cpu_mem_pkg::DMEM_WORDS_DEF
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        run_i,
    input  logic        mem_read_i,
    input  logic        mem_write_i,
    input  logic        mem_to_reg_i,
    input  logic        jump_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [31:0] alu_result_i,
    input  logic [31:0] pc4_i,
    input  logic [15:0] switch_i,
    output logic [31:0] wb_data_o,
    output logic        io_wr_o,
    output logic [31:0] io_wdata_o,
    output logic [15:0] led_o
);

    localparam int DW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic          is_io;
    logic          sw_rd;
    logic [DW-1:0] idx;
    logic [31:0]   load_data;

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    assign is_io = (addr_i >= cpu_mem_pkg::IO_BASE);
    assign idx   = addr_i[DW+1:2];
    assign sw_rd = mem_read_i && is_io && (addr_i == cpu_mem_pkg::SW_ADDR);

    // data memory, async read
    always_ff @(posedge clk) begin
        if (run_i && mem_write_i && !is_io) begin
            dmem[idx] <= wdata_i;
        end
    end

    // switches zero-extended, other io reads give 0
    always_comb begin
        if (sw_rd) begin
            load_data = {16'd0, switch_i};
        end else if (is_io) begin
            load_data = '0;
        end else begin
            load_data = dmem[idx];
        end
    end

    // ------------------------------------------------------------------------
    // led output
    // ------------------------------------------------------------------------
    // strobe for the cycle of the store
    assign io_wr_o    = run_i && mem_write_i && is_io && (addr_i == cpu_mem_pkg::LED_ADDR);
    assign io_wdata_o = wdata_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            led_o <= '0;
        end else if (io_wr_o) begin
            led_o <= io_wdata_o[15:0];
        end
    end

    // write-back select
    // link first, then load data, then alu
    always_comb begin
        if (jump_i) begin
            wb_data_o = pc4_i;
        end else if (mem_to_reg_i) begin
            wb_data_o = load_data;
        end else begin
            wb_data_o = alu_result_i;
        end
    end

    // only the two mapped io words are ever touched
    a_io_addr : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (run_i && (mem_read_i || mem_write_i) && is_io) |->
            (addr_i == cpu_mem_pkg::LED_ADDR || addr_i == cpu_mem_pkg::SW_ADDR)
    );

endmodule

// File: project.f
+incdir+sim
hw/cpu_isa_pkg.sv
hw/cpu_mem_pkg.sv
hw/ifetch.sv
hw/decoder.sv
hw/alu.sv
hw/mem_or_io.sv
hw/cpu.sv
sim/tb_cpu.sv

// File: sim/tb_asm.svh
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// operation kinds for the reference model
localparam int K_ADD = 0;
localparam int K_SUB = 1;
localparam int K_AND = 2;
localparam int K_OR  = 3;
localparam int K_XOR = 4;
localparam int K_SLT = 5;
localparam int K_SLL = 6;
localparam int K_SRL = 7;
localparam int K_SRA = 8;
localparam int K_BEQ = 9;
localparam int K_BNE = 10;

// markers left in x3 by the two paths of a branch
localparam logic [11:0] MARK_T  = 12'h5a1;
localparam logic [11:0] MARK_NT = 12'h0c3;

// ----------------------------------------------------------------------------
// instruction encoders
// ----------------------------------------------------------------------------
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, cpu_isa_pkg::OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

// sw only, funct3 fixed to word
function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_isa_pkg::OPC_BRANCH};
endfunction

// lui
function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, cpu_isa_pkg::OPC_LUI};
endfunction

// jal
function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_isa_pkg::OPC_JAL};
endfunction

// ----------------------------------------------------------------------------
// expected value of one result, straight from the isa rules
// ----------------------------------------------------------------------------
function automatic logic [31:0] expected_result(input int kind, input logic [31:0] a,
                                                input logic [31:0] b);
    case (kind)
        K_ADD:   return a + b;
        // wraps modulo 2^32
        K_SUB:   return a - b;
        K_AND:   return a & b;
        K_OR:    return a | b;
        K_XOR:   return a ^ b;
        K_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        // shift amount from the low 5 bits only
        K_SLL:   return a << b[4:0];
        K_SRL:   return a >> b[4:0];
        K_SRA:   return $signed(a) >>> b[4:0];
        K_BEQ:   return {20'd0, (a == b) ? MARK_T : MARK_NT};
        K_BNE:   return {20'd0, (a != b) ? MARK_T : MARK_NT};
        default: return 32'hdead_beef;
    endcase
endfunction

`endif

// File: sim/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    `include "tb_asm.svh"

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int ADDR_W     = $clog2(IMEM_WORDS);
    // bounds for the watchdog
    localparam int N_PROGS    = 6;
    localparam int MAX_WORDS  = 64;

    logic              clk;
    logic              rst_n_i;
    logic              run_i;
    logic              prog_we_i;
    logic [ADDR_W-1:0] prog_addr_i;
    logic [31:0]       prog_data_i;
    logic [15:0]       switch_i;
    logic              io_wr_o;
    logic [31:0]       io_wdata_o;
    logic [15:0]       led_o;

    int          seed = 32'h73508b8b;
    logic [31:0] prog [$];
    logic [31:0] exp_q [$];
    logic [31:0] want;
    logic [31:0] led_want;
    logic        led_pending = 1'b0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          checks = 0;

    cpu #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) dut0 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .run_i      (run_i),
        .prog_we_i  (prog_we_i),
        .prog_addr_i(prog_addr_i),
        .prog_data_i(prog_data_i),
        .switch_i   (switch_i),
        .io_wr_o    (io_wr_o),
        .io_wdata_o (io_wdata_o),
        .led_o      (led_o)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // program building
    // ------------------------------------------------------------------------
    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // byte address of the next emitted word
    function automatic logic [31:0] here();
        return 32'(prog.size()) << 2;
    endfunction

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        // addi sign-extends, so round the upper part
        hi = value + 32'h800;
        emit(u_type(rd, hi[31:12]));
        emit(i_type(cpu_isa_pkg::OPC_OP_IMM, cpu_isa_pkg::F3_ADD_SUB, rd, rd, value[11:0]));
    endtask

    // x0 base, the 12-bit offset sign-extends onto the io page
    task automatic store_led(input logic [4:0] rs);
        emit(s_type(rs, 5'd0, cpu_mem_pkg::LED_ADDR[11:0]));
    endtask

    task automatic reg_op_case(input logic [6:0] f7, input logic [2:0] f3, input int kind,
                               input logic [31:0] a, input logic [31:0] b);
        emit(r_type(f7, f3, 5'd3, 5'd1, 5'd2));
        store_led(5'd3);
        exp_q.push_back(expected_result(kind, a, b));
    endtask

    task automatic imm_op_case(input logic [2:0] f3, input int kind, input logic [31:0] a,
                               input logic [11:0] imm);
        emit(i_type(cpu_isa_pkg::OPC_OP_IMM, f3, 5'd3, 5'd1, imm));
        store_led(5'd3);
        exp_q.push_back(expected_result(kind, a, {{20{imm[11]}}, imm}));
    endtask

    // taken path skips the not-taken marker, both paths meet at the store
    task automatic branch_case(input logic [2:0] f3, input int kind, input logic [31:0] a,
                               input logic [31:0] b);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(b_type(f3, 5'd1, 5'd2, 13'd12));
        emit(i_type(cpu_isa_pkg::OPC_OP_IMM, cpu_isa_pkg::F3_ADD_SUB, 5'd3, 5'd0, MARK_NT));
        emit(j_type(5'd0, 21'd8));
        emit(i_type(cpu_isa_pkg::OPC_OP_IMM, cpu_isa_pkg::F3_ADD_SUB, 5'd3, 5'd0, MARK_T));
        store_led(5'd3);
        exp_q.push_back(expected_result(kind, a, b));
    endtask

    // load with the core stopped, then run until every expected write is seen
    task automatic run_program(input int hold);
        emit(j_type(5'd0, 21'd0));
        for (int k = 0; k < prog.size(); k++) begin
            @(negedge clk);
            prog_we_i   = 1'b1;
            prog_addr_i = ADDR_W'(k);
            prog_data_i = prog[k];
        end
        @(negedge clk);
        prog_we_i = 1'b0;
        repeat (hold) @(negedge clk);
        run_i = 1'b1;
        while (exp_q.size() != 0) @(negedge clk);
        run_i = 1'b0;
        prog.delete();
    endtask

    // ------------------------------------------------------------------------
    // checker, io writes matched in order
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n_i) begin
            // led register took the previous strobe's word
            if (led_pending) begin
                assert (led_o == led_want[15:0]) else begin
                    value_errs++;
                    $display("FAIL %0t: led_o %h, expected %h", $time, led_o, led_want[15:0]);
                end
            end
            led_pending = 1'b0;
            if (io_wr_o) begin
                assert (run_i) else begin
                    other_errs++;
                    $display("LED write strobe while run_i is low at %0t", $time);
                end
                assert (exp_q.size() != 0) else begin
                    other_errs++;
                    $display("LED write at %0t that no program step expects", $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    checks++;
                    assert (io_wdata_o == want) else begin
                        value_errs++;
                        $display("FAIL %0t: io_wdata_o %h, expected %h", $time, io_wdata_o, want);
                    end
                    led_want    = want;
                    led_pending = 1'b1;
                end
            end
        end
    end

    // watchdog, every program loads and runs within its budget
    initial begin
        #(N_PROGS * (MAX_WORDS + 64) * 4 + 200);
        $display("timeout: the programs did not finish their LED writes in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] pos;
        logic [11:0] imm;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        run_i       = 1'b0;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        switch_i    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // r-type ops over random operand pairs
        for (int p = 0; p < 2; p++) begin
            a = $random(seed);
            b = $random(seed);
            load_const(5'd1, a);
            load_const(5'd2, b);
            reg_op_case(7'd0, cpu_isa_pkg::F3_ADD_SUB, K_ADD, a, b);
            reg_op_case(cpu_isa_pkg::F7_ALT, cpu_isa_pkg::F3_ADD_SUB, K_SUB, a, b);
            reg_op_case(7'd0, cpu_isa_pkg::F3_AND, K_AND, a, b);
            reg_op_case(7'd0, cpu_isa_pkg::F3_OR, K_OR, a, b);
            reg_op_case(7'd0, cpu_isa_pkg::F3_XOR, K_XOR, a, b);
            reg_op_case(7'd0, cpu_isa_pkg::F3_SLT, K_SLT, a, b);
            reg_op_case(7'd0, cpu_isa_pkg::F3_SLL, K_SLL, a, b);
            reg_op_case(7'd0, cpu_isa_pkg::F3_SRL_SRA, K_SRL, a, b);
            reg_op_case(cpu_isa_pkg::F7_ALT, cpu_isa_pkg::F3_SRL_SRA, K_SRA, a, b);
        end
        run_program(0);

        // immediates, negative first then positive
        a = $random(seed);
        load_const(5'd1, a);
        for (int j = 0; j < 2; j++) begin
            r   = $random(seed);
            imm = {(j == 0), r[10:0]};
            imm_op_case(cpu_isa_pkg::F3_ADD_SUB, K_ADD, a, imm);
            imm_op_case(cpu_isa_pkg::F3_AND, K_AND, a, imm);
            imm_op_case(cpu_isa_pkg::F3_OR, K_OR, a, imm);
            imm_op_case(cpu_isa_pkg::F3_XOR, K_XOR, a, imm);
            imm_op_case(cpu_isa_pkg::F3_SLT, K_SLT, a, imm);
        end
        r = $random(seed);
        emit(u_type(5'd4, r[19:0]));
        store_led(5'd4);
        exp_q.push_back({r[19:0], 12'd0});
        run_program(0);

        // data memory round trip
        a = $random(seed);
        r = $random(seed);
        b = {22'd0, r[7:0], 2'b00};
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(s_type(5'd1, 5'd2, 12'd0));
        emit(i_type(cpu_isa_pkg::OPC_LOAD, 3'b010, 5'd3, 5'd2, 12'd0));
        store_led(5'd3);
        exp_q.push_back(a);
        run_program(0);

        // branches both ways, then jalr to an odd target and jal
        a = $random(seed);
        r = $random(seed);
        branch_case(cpu_isa_pkg::F3_BEQ, K_BEQ, a, a);
        branch_case(cpu_isa_pkg::F3_BEQ, K_BEQ, a, r);
        branch_case(cpu_isa_pkg::F3_BNE, K_BNE, a, a);
        branch_case(cpu_isa_pkg::F3_BNE, K_BNE, a, r);
        pos = here();
        // jalr at pos+8, target pos+16 with bit 0 set
        load_const(5'd6, pos + 32'd17);
        emit(i_type(cpu_isa_pkg::OPC_JALR, 3'b000, 5'd7, 5'd6, 12'd0));
        store_led(5'd0);
        store_led(5'd7);
        exp_q.push_back(pos + 32'd8 + 32'd4);
        // an odd landing pc would show in this link
        pos = here();
        emit(j_type(5'd5, 21'd8));
        store_led(5'd0);
        store_led(5'd5);
        exp_q.push_back(pos + 32'd4);
        run_program(0);

        // switch read
        r        = $random(seed);
        switch_i = r[15:0];
        emit(i_type(cpu_isa_pkg::OPC_LOAD, 3'b010, 5'd3, 5'd0, cpu_mem_pkg::SW_ADDR[11:0]));
        store_led(5'd3);
        exp_q.push_back({16'd0, r[15:0]});
        run_program(0);

        // x0 stays zero, first word is a led store held off by run_i
        r = $random(seed);
        store_led(5'd0);
        exp_q.push_back(32'd0);
        emit(i_type(cpu_isa_pkg::OPC_OP_IMM, cpu_isa_pkg::F3_ADD_SUB, 5'd0, 5'd0,
                    r[11:0] | 12'h001));
        emit(u_type(5'd0, r[31:12]));
        store_led(5'd0);
        exp_q.push_back(32'd0);
        run_program(10);

        // let the last led check happen
        repeat (2) @(negedge clk);
        $display("errors: %0d value, %0d other, %0d writes checked",
                 value_errs, other_errs, checks);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
